// File: include/elink_macros.svh
`ifndef ELINK_MACROS_SVH
`define ELINK_MACROS_SVH

// ##################################################
// packet and register file geometry
// ##################################################
`define ELINK_PW             104     // mesh packet width
`define ELINK_RFAW           6       // reg index lives in addr[7:2]

// ##################################################
// config block register map
// ##################################################
`define E_RESET              6'd0    // soft reset, tx in bit 0, rx in bit 1
`define E_CLK                6'd1    // pll clock setting
`define E_CHIPID             6'd2    // chip id

// block select, compared against addr[10:8]
`define ELINK_CFG_BLOCK      3'h2

// ##################################################
// reset values
// ##################################################
`define ELINK_CLK_DEFAULT    16'h573 // all clocks on, lowest speed
`define ELINK_CHIPID_DEFAULT 12'h808

`endif

// File: hdl/elink_pkg.sv
`include "elink_macros.svh"

package elink_pkg;

   // ##################################################
   // plain vectors
   // ##################################################
   typedef logic [`ELINK_PW-1:0] elink_packet_t;  // raw mesh packet
   typedef logic [31:0]          emesh_addr_t;
   typedef logic [31:0]          emesh_data_t;
   typedef logic [11:0]          chipid_t;
   typedef logic [15:0]          clk_config_t;    // pll setting

   // one-hot reg select
   // bit 0 reset, bit 1 clk, bit 2 chipid, zero when not a config write
   typedef logic [2:0]           cfg_sel_t;

   // ##################################################
   // pipeline payloads
   // ##################################################

   // unpacked mesh transaction
   typedef struct packed {
      logic        write;     // 1 = write, 0 = read
      logic [1:0]  datamode;  // access size
      logic [4:0]  ctrlmode;
      emesh_addr_t dstaddr;
      emesh_data_t data;
      emesh_addr_t srcaddr;   // return address for reads
   } emesh_txn_t;

   // decode -> regs
   typedef struct packed {
      emesh_txn_t txn;
      cfg_sel_t   sel;        // which config reg, if any
   } cfg_txn_t;

endpackage

// File: hdl/ecfg_decode.sv
`timescale 1ns/10ps
`include "elink_macros.svh"

// stage 1 of the tx write path
// unpacks the raw packet and flags writes to our own config block
module ecfg_decode #(
   parameter logic [11:0] ID = 12'h000   // link id, matched against addr[31:20]
) (
   input  logic                    clk,
   input  logic                    por_reset,
   input  logic                    in_valid,
   output logic                    in_ready,
   input  elink_pkg::elink_packet_t in_packet,
   output logic                    dec_valid,
   input  logic                    dec_ready,
   output elink_pkg::cfg_txn_t     dec_txn
);

   import elink_pkg::*;

   emesh_txn_t             txn;        // sliced packet
   cfg_sel_t               sel;
   logic [`ELINK_RFAW-1:0] reg_idx;
   logic                   id_match;
   logic                   blk_match;
   logic                   cfg_wr;     // write into our config block
   logic                   rdy_en;     // first edge after reset seen
   logic                   stage_valid;
   cfg_txn_t               stage_q;

   // ##################################################
   // packet unpack
   // ##################################################
   assign txn.write    = in_packet[0];
   assign txn.datamode = in_packet[2:1];
   assign txn.ctrlmode = in_packet[7:3];
   assign txn.dstaddr  = in_packet[39:8];
   assign txn.data     = in_packet[71:40];
   assign txn.srcaddr  = in_packet[103:72];

   // ##################################################
   // address decode
   // ##################################################
   assign reg_idx   = txn.dstaddr[`ELINK_RFAW+1:2];
   assign id_match  = (txn.dstaddr[31:20] == ID);
   assign blk_match = (txn.dstaddr[10:8] == `ELINK_CFG_BLOCK);
   assign cfg_wr    = txn.write & id_match & blk_match;

   // unnamed offsets in the block fall through as traffic
   assign sel[0] = cfg_wr & (reg_idx == `E_RESET);
   assign sel[1] = cfg_wr & (reg_idx == `E_CLK);
   assign sel[2] = cfg_wr & (reg_idx == `E_CHIPID);

   // ##################################################
   // stage register
   // ##################################################

   // stays low through reset, opens one edge after release
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) rdy_en <= 1'b0;
      else           rdy_en <= 1'b1;
   end

   assign in_ready = rdy_en & (~stage_valid | dec_ready); // empty or draining

   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         stage_valid <= 1'b0;
      end else if (in_ready) begin
         stage_valid <= in_valid;   // refill or go empty
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         stage_q <= '{txn: txn, sel: sel};
      end
   end

   assign dec_valid = stage_valid;
   assign dec_txn   = stage_q;

   // at most one config reg targeted per item
   a_sel_onehot: assert property (@(posedge clk) disable iff (por_reset)
      dec_valid |-> $onehot0(dec_txn.sel));

endmodule

// File: hdl/ecfg_regs.sv
`timescale 1ns/10ps
`include "elink_macros.svh"

// stage 2 of the tx write path
// soaks up config writes, forwards everything else in order
module ecfg_regs (
   input  logic                   clk,
   input  logic                   por_reset,
   input  logic                   dec_valid,
   output logic                   dec_ready,
   input  elink_pkg::cfg_txn_t    dec_txn,
   output logic                   fwd_valid,
   input  logic                   fwd_ready,
   output elink_pkg::emesh_txn_t  fwd_txn,
   output logic                   etx_soft_reset,  // tx soft reset level
   output logic                   erx_soft_reset,  // rx soft reset level
   output elink_pkg::clk_config_t clk_config,      // to pll
   output elink_pkg::chipid_t     chipid
);

   import elink_pkg::*;

   logic        is_cfg;       // item targets a config reg
   logic        fwd_free;     // forward slot empty or leaving
   logic        dec_accept;
   logic        cfg_wr;
   logic        fwd_load;
   logic        fwd_vld;
   emesh_txn_t  fwd_q;
   logic [1:0]  reset_reg;    // {rx, tx}
   clk_config_t clk_reg;
   chipid_t     chipid_reg;

   // ##################################################
   // handshake
   // ##################################################
   assign is_cfg   = |dec_txn.sel;
   assign fwd_free = ~fwd_vld | fwd_ready;

   // config writes never need the forward slot
   assign dec_ready  = is_cfg | fwd_free;
   assign dec_accept = dec_valid & dec_ready;
   assign cfg_wr     = dec_accept & is_cfg;
   assign fwd_load   = dec_accept & ~is_cfg;

   // ##################################################
   // forward register
   // ##################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         fwd_vld <= 1'b0;
      end else if (fwd_free) begin
         fwd_vld <= fwd_load;        // empties when a cfg write goes by
      end
   end

   always_ff @(posedge clk) begin
      if (fwd_load) begin
         fwd_q <= dec_txn.txn;
      end
   end

   assign fwd_valid = fwd_vld;
   assign fwd_txn   = fwd_q;

   // ##################################################
   // soft reset
   // ##################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         reset_reg <= 2'b00;
      end else if (cfg_wr && dec_txn.sel[0]) begin
         reset_reg <= dec_txn.txn.data[1:0];
      end
   end

   assign etx_soft_reset = reset_reg[0];
   assign erx_soft_reset = reset_reg[1];

   // ##################################################
   // pll clock setting
   // ##################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         clk_reg <= `ELINK_CLK_DEFAULT;   // all on, slowest
      end else if (cfg_wr && dec_txn.sel[1]) begin
         clk_reg <= dec_txn.txn.data[15:0];
      end
   end

   assign clk_config = clk_reg;

   // ##################################################
   // chip id
   // ##################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         chipid_reg <= `ELINK_CHIPID_DEFAULT;
      end else if (cfg_wr && dec_txn.sel[2]) begin
         chipid_reg <= dec_txn.txn.data[11:0];  // full 12 bits kept
      end
   end

   assign chipid = chipid_reg;

   // a consumed config write must not show up downstream
   a_cfg_dropped: assert property (@(posedge clk) disable iff (por_reset)
      cfg_wr |=> !$rose(fwd_valid));

endmodule

// File: hdl/etx_fifo.sv
`timescale 1ns/10ps

// small sync fifo in front of the link transmitter
module etx_fifo #(
   parameter int DEPTH = 4   // power of two
) (
   input  logic                  clk,
   input  logic                  por_reset,
   input  logic                  fwd_valid,
   output logic                  fwd_ready,    // not full
   input  elink_pkg::emesh_txn_t fwd_txn,
   output logic                  out_valid,    // not empty
   input  logic                  out_ready,
   output elink_pkg::emesh_txn_t out_txn
);

   import elink_pkg::*;

   localparam int            AW       = $clog2(DEPTH);
   localparam logic [AW:0]   FULL_CNT = (AW+1)'(DEPTH);

   emesh_txn_t    mem [DEPTH];  // storage, no reset
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;        // one extra bit for full
   logic          wr;
   logic          rd;

   // ##################################################
   // flags
   // ##################################################
   assign fwd_ready = (count != FULL_CNT);
   assign out_valid = (count != '0);
   assign wr        = fwd_valid & fwd_ready;
   assign rd        = out_valid & out_ready;

   // ##################################################
   // pointers and occupancy
   // ##################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is 2^n
         if (rd) rd_ptr <= rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // both or neither
         endcase
      end
   end

   // ##################################################
   // storage
   // ##################################################
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_ptr] <= fwd_txn;
      end
   end

   assign out_txn = mem[rd_ptr];   // head visible the cycle after write

   // full fifo must not advance the write side
   a_no_wr_full: assert property (@(posedge clk) disable iff (por_reset)
      (count == FULL_CNT) |=> (wr_ptr == $past(wr_ptr)));

   // empty fifo must not advance the read side
   a_no_rd_empty: assert property (@(posedge clk) disable iff (por_reset)
      (count == '0) |=> (rd_ptr == $past(rd_ptr)));

endmodule

// File: hdl/elink_txwr.sv
`timescale 1ns/10ps

// tx write path top: decode -> config regs -> tx fifo
module elink_txwr #(
   parameter logic [11:0] ID         = 12'h000,  // this link's id
   parameter int          FIFO_DEPTH = 4
) (
   input  logic                     clk,
   input  logic                     por_reset,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  elink_pkg::elink_packet_t in_packet,
   output logic                     out_valid,
   input  logic                     out_ready,
   output elink_pkg::emesh_txn_t    out_txn,
   output logic                     etx_soft_reset,
   output logic                     erx_soft_reset,
   output elink_pkg::clk_config_t   clk_config,
   output elink_pkg::chipid_t       chipid
);

   import elink_pkg::*;

   logic       dec_valid;   // stage 1 -> stage 2
   logic       dec_ready;
   cfg_txn_t   dec_txn;
   logic       fwd_valid;   // stage 2 -> fifo
   logic       fwd_ready;
   emesh_txn_t fwd_txn;

   // ##################################################
   // pipeline
   // ##################################################
   ecfg_decode #(.ID(ID)) i_decode (
      .clk       (clk),
      .por_reset (por_reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_packet (in_packet),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec_txn   (dec_txn)
   );

   ecfg_regs i_regs (
      .clk            (clk),
      .por_reset      (por_reset),
      .dec_valid      (dec_valid),
      .dec_ready      (dec_ready),
      .dec_txn        (dec_txn),
      .fwd_valid      (fwd_valid),
      .fwd_ready      (fwd_ready),
      .fwd_txn        (fwd_txn),
      .etx_soft_reset (etx_soft_reset),
      .erx_soft_reset (erx_soft_reset),
      .clk_config     (clk_config),
      .chipid         (chipid)
   );

   etx_fifo #(.DEPTH(FIFO_DEPTH)) i_fifo (
      .clk       (clk),
      .por_reset (por_reset),
      .fwd_valid (fwd_valid),
      .fwd_ready (fwd_ready),
      .fwd_txn   (fwd_txn),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_txn   (out_txn)
   );

endmodule

// File: tb/tb_elink_txwr.sv
`timescale 1ns/10ps

module tb_elink_txwr;

   import elink_pkg::*;

   localparam logic [11:0] LINK_ID = 12'h810;
   localparam int N_PASS = 40;
   localparam int N_CFG  = 6;     // two rounds over the three regs
   localparam int N_NEAR = 12;
   localparam int N_MIX  = 200;
   localparam int CYCLE_LIMIT = 4 * (N_PASS + N_CFG + N_NEAR + N_MIX) + 200;

   logic          clk = 1'b0;
   logic          por_reset;
   logic          in_valid;
   logic          in_ready;
   elink_packet_t in_packet;
   logic          out_valid;
   logic          out_ready;
   emesh_txn_t    out_txn;
   logic          etx_soft_reset;
   logic          erx_soft_reset;
   clk_config_t   clk_config;
   chipid_t       chipid;

   elink_packet_t exp_q[$];      // packets the dut still owes us
   logic [1:0]    exp_reset;     // shadow {rx, tx}
   logic [15:0]   exp_clk;
   logic [11:0]   exp_chipid;
   logic [31:0]   rnd_state;     // stimulus stream
   logic [31:0]   rdy_state = ~32'h548b;   // out_ready stream
   logic          bp_mode;       // random out_ready when set
   string         cur_test;
   int            errors;
   int            test_errors;
   int            tests_run;
   int            tests_bad;
   int            out_count;
   int            cycles;

   elink_txwr #(.ID(LINK_ID), .FIFO_DEPTH(4)) i_dut (
      .clk            (clk),
      .por_reset      (por_reset),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .in_packet      (in_packet),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_txn        (out_txn),
      .etx_soft_reset (etx_soft_reset),
      .erx_soft_reset (erx_soft_reset),
      .clk_config     (clk_config),
      .chipid         (chipid)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout, test %s hung with %0d packets outstanding", cur_test, exp_q.size());
         $display("sim failed");
         $finish;
      end
   end

   // ##################################################
   // random numbers and packet building
   // ##################################################
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rnd_state = xorshift(rnd_state);
      return rnd_state;
   endfunction

   // layout {srcaddr, data, dstaddr, ctrlmode, datamode, write}
   function automatic elink_packet_t build(input logic wr, input logic [31:0] dst,
                                           input logic [31:0] dat);
      logic [31:0] src;
      logic [31:0] r;
      src = next_rand();
      r   = next_rand();
      return {src, dat, dst, r[4:0], r[6:5], wr};
   endfunction

   // id in [31:20], block in [10:8], reg index in [7:2], rest random
   function automatic logic [31:0] cfg_addr(input logic [11:0] id, input logic [2:0] blk,
                                            input logic [5:0] idx);
      logic [31:0] r;
      r = next_rand();
      return {id, r[8:0], blk, idx, r[10:9]};
   endfunction

   function automatic elink_packet_t random_packet();
      logic [31:0] dst;
      logic [31:0] dat;
      dst = next_rand();
      dat = next_rand();
      return build(dst[23], dst, dat);   // write flag random too
   endfunction

   // reference: -1 forwarded, else index of the reg it hits
   function automatic int cfg_target(input elink_packet_t p);
      logic [31:0] addr;
      addr = p[39:8];
      if (p[0] !== 1'b1) return -1;            // reads pass through
      if (addr[31:20] != LINK_ID) return -1;
      if (addr[10:8] != 3'd2) return -1;       // config block only
      if (addr[7:2] > 6'd2) return -1;         // unnamed offsets
      return int'(addr[7:2]);
   endfunction

   // ##################################################
   // checks and reporting
   // ##################################################
   task automatic count_error();
      errors++;
      test_errors++;
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s got %h expected %h", name, got, exp);
         count_error();
      end
   endtask

   task automatic check_regs();
      check("etx_soft_reset", 32'(etx_soft_reset), 32'(exp_reset[0]));
      check("erx_soft_reset", 32'(erx_soft_reset), 32'(exp_reset[1]));
      check("clk_config", 32'(clk_config), 32'(exp_clk));
      check("chipid", 32'(chipid), 32'(exp_chipid));
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors != 0) tests_bad++;
      $display("test %s: %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "bad",
               test_errors);
   endtask

   // ##################################################
   // driving
   // ##################################################

   // called on a falling edge, returns on a falling edge
   task automatic send(input elink_packet_t p);
      case (cfg_target(p))
         0:       exp_reset  = p[41:40];       // data is bits 71:40
         1:       exp_clk    = p[55:40];
         2:       exp_chipid = p[51:40];
         default: exp_q.push_back(p);
      endcase
      in_packet = p;
      in_valid  = 1'b1;
      while (!in_ready) @(negedge clk);
      @(negedge clk);                           // taken at the rising edge between
      in_valid = 1'b0;
   endtask

   task automatic send_addressed(input logic wr, input logic [11:0] id, input logic [2:0] blk,
                                 input logic [5:0] idx);
      logic [31:0] addr;
      logic [31:0] data;
      addr = cfg_addr(id, blk, idx);
      data = next_rand();
      send(build(wr, addr, data));
   endtask

   // quiet input side and empty output for a few cycles
   task automatic settle();
      int quiet;
      quiet = 0;
      while (quiet < 4) begin
         @(negedge clk);
         quiet = (in_ready && !out_valid) ? quiet + 1 : 0;
      end
      if (exp_q.size() != 0) begin
         $display("%0d forwarded packets never reached the output", exp_q.size());
         count_error();
      end
   endtask

   always @(negedge clk) begin
      rdy_state = xorshift(rdy_state);
      out_ready = bp_mode ? rdy_state[9] : 1'b1;   // low half the time
   end

   // comparator, pops one expected packet per output transfer
   always @(posedge clk) begin
      elink_packet_t exp_p;
      if (!por_reset && out_valid && out_ready) begin
         out_count++;
         if (exp_q.size() == 0) begin
            $display("unexpected output, dstaddr %h, nothing was owed", out_txn.dstaddr);
            count_error();
         end else begin
            exp_p = exp_q.pop_front();
            check("out_txn.write", 32'(out_txn.write), 32'(exp_p[0]));
            check("out_txn.datamode", 32'(out_txn.datamode), 32'(exp_p[2:1]));
            check("out_txn.ctrlmode", 32'(out_txn.ctrlmode), 32'(exp_p[7:3]));
            check("out_txn.dstaddr", out_txn.dstaddr, exp_p[39:8]);
            check("out_txn.data", out_txn.data, exp_p[71:40]);
            check("out_txn.srcaddr", out_txn.srcaddr, exp_p[103:72]);
         end
      end
   end

   // ##################################################
   // test sequence
   // ##################################################
   initial begin
      elink_packet_t p;
      logic [31:0]   r;
      int            start;
      por_reset = 1'b1;
      in_valid  = 1'b0;
      in_packet = '0;
      out_ready = 1'b1;
      bp_mode   = 1'b0;
      rnd_state = 32'h548b;
      exp_reset  = 2'b00;       // reset values of the register map
      exp_clk    = 16'h573;
      exp_chipid = 12'h808;
      cur_test   = "reset";
      repeat (5) @(posedge clk);
      @(negedge clk);
      por_reset = 1'b0;

      begin_test("reset");
      check("out_valid", 32'(out_valid), 32'd0);
      check("in_ready", 32'(in_ready), 32'd0);     // not before the first edge
      check_regs();
      @(negedge clk);
      check("in_ready", 32'(in_ready), 32'd1);
      end_test();

      begin_test("pass_through");
      for (int i = 0; i < N_PASS; i++) begin
         p = random_packet();
         while (cfg_target(p) >= 0) p = random_packet();
         send(p);
      end
      settle();
      check_regs();
      end_test();

      begin_test("config_writes");
      start = out_count;
      for (int i = 0; i < N_CFG; i++) send_addressed(1'b1, LINK_ID, 3'd2, 6'(i % 3));
      settle();
      check("forwarded count", 32'(out_count - start), 32'd0);
      check_regs();
      end_test();

      begin_test("near_misses");
      start = out_count;
      for (int k = 0; k < 3; k++) send_addressed(1'b1, LINK_ID + 12'(k + 1), 3'd2, 6'(k));
      for (int b = 0; b < 8; b++) begin
         if (b != 2) send_addressed(1'b1, LINK_ID, 3'(b), 6'(b % 3));   // wrong block
      end
      send_addressed(1'b1, LINK_ID, 3'd2, 6'd3);    // unnamed offset
      send_addressed(1'b0, LINK_ID, 3'd2, 6'd1);    // read of clk reg
      settle();
      check("forwarded count", 32'(out_count - start), 32'(N_NEAR));
      check_regs();
      end_test();

      begin_test("back_pressure");
      bp_mode = 1'b1;
      for (int i = 0; i < N_MIX; i++) begin
         r = next_rand();
         if (r[1:0] == 2'b00) send_addressed(1'b1, LINK_ID, 3'd2, 6'(int'(r[9:8]) % 3));
         else send(random_packet());
      end
      settle();
      bp_mode = 1'b0;
      check_regs();
      end_test();

      $display("%0d tests, %0d with errors, %0d errors total", tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+include
hdl/elink_pkg.sv
hdl/ecfg_decode.sv
hdl/ecfg_regs.sv
hdl/etx_fifo.sv
hdl/elink_txwr.sv
tb/tb_elink_txwr.sv

// File: Makefile
TOP = tb_elink_txwr

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir
